// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and checks the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_ddr_addr_cmd_phy \
	-f verilog.f -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"

grep -q "^Simulation finished: PASS$" sim.log \
	&& echo "testbench passed" \
	|| { echo "testbench did not pass"; exit 1; }

// ==== verification/tb_ddr_addr_cmd_phy.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_phy_consts.svh"

module tb_ddr_addr_cmd_phy;

	import addr_cmd_pkg::*;

	localparam int CLK_HALF_NS = 20;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT = 200;
	localparam int TABLE_ROWS = 10;
	localparam int RANDOM_WORDS = 300;

	typedef struct packed {
		mem_addr_t lo_addr;
		mem_addr_t hi_addr;
		mem_cs_n_t lo_cs_n;
		mem_cs_n_t hi_cs_n;
		mem_cke_t lo_cke;
		mem_cke_t hi_cke;
		logic [3:0] gap;
	} row_t;

	typedef struct packed {
		logic is_hi;
		mem_addr_t addr;
		mem_cs_n_t cs_n;
		mem_cke_t cke;
	} slot_t;

	// every slot has a chip select low so the monitor can tell it from a NOP
	// a zero gap raises the next request as soon as ack has fallen
	localparam row_t CMD_TABLE [TABLE_ROWS] = '{
		'{14'h0400, 14'h0000, 2'b10, 2'b10, 2'b00, 2'b01, 4'd3},
		'{14'h1234, 14'h2abc, 2'b00, 2'b01, 2'b01, 2'b11, 4'd0},
		'{14'h3fff, 14'h0001, 2'b01, 2'b10, 2'b11, 2'b11, 4'd0},
		'{14'h0a5a, 14'h15a5, 2'b10, 2'b00, 2'b10, 2'b10, 4'd1},
		'{14'h0000, 14'h3ffe, 2'b01, 2'b01, 2'b11, 2'b01, 4'd0},
		'{14'h2222, 14'h1111, 2'b00, 2'b00, 2'b01, 2'b00, 4'd5},
		'{14'h0f0f, 14'h30f0, 2'b10, 2'b01, 2'b00, 2'b11, 4'd0},
		'{14'h0042, 14'h0024, 2'b01, 2'b00, 2'b11, 2'b10, 4'd0},
		'{14'h1fff, 14'h2000, 2'b00, 2'b10, 2'b10, 2'b01, 4'd2},
		'{14'h0777, 14'h3888, 2'b10, 2'b10, 2'b01, 2'b11, 4'd0}
	};

	logic pll_afi_clk;
	logic arst_n;
	logic cmd_req;
	afi_addr_t afi_address;
	afi_cs_n_t afi_cs_n;
	afi_cke_t afi_cke;
	mem_ck_t mem_clk_enable;

	logic cmd_ack;
	mem_addr_t mem_address;
	mem_cs_n_t mem_cs_n;
	mem_cke_t mem_cke;
	mem_ck_t mem_ck;
	mem_ck_t mem_ck_n;

	slot_t exp_q [$];
	slot_t mon_slot;
	logic monitor_on = 1'b0;
	logic hi_due = 1'b0;
	logic prev_req = 1'b0;
	logic prev_ack = 1'b0;
	mem_ck_t prev_en = '0;
	mem_ck_t prev_ck = '0;
	mem_cke_t last_cke = `RESET_CKE;
	int ck_phase = 0;
	logic [31:0] rng_state = 32'd8694;

	ddr_addr_cmd_phy #(
		.REGISTER_C2P(1)
	) dut_i (
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.cmd_req(cmd_req),
		.afi_address(afi_address),
		.afi_cs_n(afi_cs_n),
		.afi_cke(afi_cke),
		.mem_clk_enable(mem_clk_enable),
		.cmd_ack(cmd_ack),
		.mem_address(mem_address),
		.mem_cs_n(mem_cs_n),
		.mem_cke(mem_cke),
		.mem_ck(mem_ck),
		.mem_ck_n(mem_ck_n)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #(CLK_HALF_NS) pll_afi_clk = ~pll_afi_clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
			abort_run("stopping at the first wrong value");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic slot_t make_slot(input logic is_hi, input mem_addr_t addr,
		input mem_cs_n_t cs_n, input mem_cke_t cke);
		return {is_hi, addr, cs_n, cke};
	endfunction

	task automatic next_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	task automatic make_random_row(output row_t row);
		logic [31:0] r;
		next_random(r);
		row.lo_addr = mem_addr_t'(r);
		row.hi_addr = mem_addr_t'(r >> 16);
		next_random(r);
		row.lo_cs_n = mem_cs_n_t'(r);
		row.hi_cs_n = mem_cs_n_t'(r >> 8);
		row.lo_cke = mem_cke_t'(r >> 16);
		row.hi_cke = mem_cke_t'(r >> 24);
		// a NOP pattern would hide the slot from the monitor
		if (row.lo_cs_n == `NOP_CS_N)
		begin
			row.lo_cs_n[0] = 1'b0;
		end
		if (row.hi_cs_n == `NOP_CS_N)
		begin
			row.hi_cs_n[0] = 1'b0;
		end
		next_random(r);
		row.gap = (r[7:0] < 8'd128) ? 4'd0 : 4'(r[9:8]);
	endtask

	task automatic wait_for_ack(input logic level);
		int cycles;
		cycles = 0;
		@(negedge pll_afi_clk);
		while (cmd_ack !== level && cycles <= WAIT_LIMIT)
		begin
			cycles++;
			@(negedge pll_afi_clk);
		end
		if (cmd_ack !== level)
		begin
			abort_run("timeout: cmd_ack did not reach the level the handshake needs");
		end
	endtask

	// four-phase transfer of one word, then the row's idle gap
	task automatic send_word(input row_t row);
		@(posedge pll_afi_clk);
		afi_address <= {row.hi_addr, row.lo_addr};
		afi_cs_n <= {row.hi_cs_n, row.lo_cs_n};
		afi_cke <= {row.hi_cke, row.lo_cke};
		cmd_req <= 1'b1;
		exp_q.push_back(make_slot(1'b0, row.lo_addr, row.lo_cs_n, row.lo_cke));
		exp_q.push_back(make_slot(1'b1, row.hi_addr, row.hi_cs_n, row.hi_cke));
		wait_for_ack(1'b1);
		@(posedge pll_afi_clk);
		cmd_req <= 1'b0;
		// the latched word must not follow the host bus once ack is up
		afi_address <= ~{row.hi_addr, row.lo_addr};
		afi_cs_n <= '0;
		wait_for_ack(1'b0);
		repeat (row.gap) @(posedge pll_afi_clk);
	endtask

	always @(posedge pll_afi_clk)
	begin
		if (monitor_on)
		begin
			ck_phase <= (ck_phase == 22) ? 0 : ck_phase + 1;
			mem_clk_enable <= (ck_phase < 15) ? {`MEM_CK_WIDTH{1'b1}} : '0;
		end
	end

	// outputs settle after the rising edge, so they are sampled on the falling one
	always @(negedge pll_afi_clk)
	begin
		if (monitor_on)
		begin
			check_value(32'(mem_ck ^ mem_ck_n), 32'({`MEM_CK_WIDTH{1'b1}}),
				"mem_ck_n is not the complement of mem_ck");
			if (prev_en == '0)
			begin
				check_value(32'(mem_ck), 32'd0, "mem_ck did not park low after enable fell");
			end
			else
			begin
				check_value(32'(mem_ck ^ prev_ck), 32'({`MEM_CK_WIDTH{1'b1}}),
					"mem_ck did not change while enabled");
			end
			if (cmd_ack && !prev_ack)
			begin
				check_value(32'(prev_req), 32'd1, "cmd_ack rose while cmd_req was low");
			end
			if (!cmd_ack && prev_ack)
			begin
				check_value(32'(prev_req), 32'd0, "cmd_ack fell while cmd_req was high");
			end
			if (mem_cs_n !== `NOP_CS_N)
			begin
				check_value(32'(exp_q.size() > 0), 32'd1, "command slot with no word sent");
				mon_slot = exp_q.pop_front();
				check_value(32'(mem_address), 32'(mon_slot.addr), "mem_address of command slot");
				check_value(32'(mem_cs_n), 32'(mon_slot.cs_n), "mem_cs_n of command slot");
				check_value(32'(mem_cke), 32'(mon_slot.cke), "mem_cke of command slot");
				hi_due = !mon_slot.is_hi;
				last_cke = mem_cke;
			end
			else
			begin
				check_value(32'(hi_due), 32'd0, "NOP between the low and high slot of a word");
				check_value(32'(mem_address), 32'd0, "mem_address during idle");
				check_value(32'(mem_cke), 32'(last_cke), "mem_cke during idle");
			end
			prev_req = cmd_req;
			prev_ack = cmd_ack;
			prev_en = mem_clk_enable;
			prev_ck = mem_ck;
		end
	end

	initial
	begin
		row_t row;
		int cycles;
		arst_n = 1'b0;
		cmd_req = 1'b0;
		afi_address = '0;
		afi_cs_n = '1;
		afi_cke = '0;
		mem_clk_enable = '0;

		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		arst_n <= 1'b1;
		@(negedge pll_afi_clk);
		check_value(32'(cmd_ack), 32'd0, "cmd_ack after reset");
		check_value(32'(mem_cs_n), 32'(`NOP_CS_N), "mem_cs_n after reset");
		check_value(32'(mem_cke), 32'(`RESET_CKE), "mem_cke after reset");
		check_value(32'(mem_address), 32'd0, "mem_address after reset");
		check_value(32'(mem_ck), 32'd0, "mem_ck after reset");
		check_value(32'(mem_ck_n), 32'({`MEM_CK_WIDTH{1'b1}}), "mem_ck_n after reset");
		@(posedge pll_afi_clk);
		monitor_on <= 1'b1;

		for (int i = 0; i < TABLE_ROWS; i++)
		begin
			send_word(CMD_TABLE[i]);
		end
		for (int i = 0; i < RANDOM_WORDS; i++)
		begin
			make_random_row(row);
			send_word(row);
		end

		cycles = 0;
		while (exp_q.size() != 0 && cycles <= WAIT_LIMIT)
		begin
			cycles++;
			@(posedge pll_afi_clk);
		end
		// a few idle cycles to check NOP slots after the last word
		repeat (4) @(posedge pll_afi_clk);

		if (exp_q.size() == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
		begin
			abort_run("not every word sent reached the command outputs");
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/addr_cmd_pkg.sv
verilog/afi_cmd_capture.sv
verilog/hr_to_fr_serializer.sv
verilog/mem_ck_pair_gen.sv
verilog/addr_cmd_pads.sv
verilog/ddr_addr_cmd_phy.sv
verification/tb_ddr_addr_cmd_phy.sv

// ==== verilog/addr_cmd_pads.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_cmd_pads #(
	parameter int REGISTER_C2P = 1
) (
	input wire logic pll_afi_clk,
	input wire logic arst_n,
	input wire logic word_valid,
	input wire addr_cmd_pkg::afi_addr_t word_address,
	input wire addr_cmd_pkg::afi_cs_n_t word_cs_n,
	input wire addr_cmd_pkg::afi_cke_t word_cke,
	input wire addr_cmd_pkg::mem_ck_t mem_clk_enable,
	output logic word_take,
	output addr_cmd_pkg::mem_addr_t mem_address,
	output addr_cmd_pkg::mem_cs_n_t mem_cs_n,
	output addr_cmd_pkg::mem_cke_t mem_cke,
	output addr_cmd_pkg::mem_ck_t mem_ck,
	output addr_cmd_pkg::mem_ck_t mem_ck_n
);

	import addr_cmd_pkg::*;

	logic c2p_valid;
	afi_addr_t c2p_address;
	afi_cs_n_t c2p_cs_n;
	afi_cke_t c2p_cke;
	logic ser_take;

	generate
		if (REGISTER_C2P == 1)
		begin : g_c2p_reg
			logic take_d;

			// capture only empties its buffer a cycle after the serializer took the copy,
			// so the copy stays invalid for the take cycle and the one after it
			always_ff @(posedge pll_afi_clk or negedge arst_n)
			begin
				if (!arst_n)
				begin
					c2p_valid <= 1'b0;
					take_d <= 1'b0;
				end
				else
				begin
					c2p_valid <= word_valid && !ser_take && !take_d;
					take_d <= ser_take;
				end
			end

			always_ff @(posedge pll_afi_clk)
			begin
				c2p_address <= word_address;
				c2p_cs_n <= word_cs_n;
				c2p_cke <= word_cke;
			end

			assign word_take = take_d;
		end
		else
		begin : g_c2p_bypass
			assign c2p_valid = word_valid;
			assign c2p_address = word_address;
			assign c2p_cs_n = word_cs_n;
			assign c2p_cke = word_cke;
			assign word_take = ser_take;
		end
	endgenerate

	hr_to_fr_serializer ser_i (
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.word_valid(c2p_valid),
		.word_address(c2p_address),
		.word_cs_n(c2p_cs_n),
		.word_cke(c2p_cke),
		.word_take(ser_take),
		.mem_address(mem_address),
		.mem_cs_n(mem_cs_n),
		.mem_cke(mem_cke)
	);

	mem_ck_pair_gen ck_gen_i (
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.mem_clk_enable(mem_clk_enable),
		.mem_ck(mem_ck),
		.mem_ck_n(mem_ck_n)
	);

endmodule

`default_nettype wire

// ==== verilog/addr_cmd_pkg.sv ====
`default_nettype none

`include "ddr_phy_consts.svh"

package addr_cmd_pkg;

	// one full-rate slot
	typedef logic [`MEM_ADDRESS_WIDTH-1:0] mem_addr_t;
	typedef logic [`MEM_CHIP_SELECT_WIDTH-1:0] mem_cs_n_t;
	typedef logic [`MEM_CLK_EN_WIDTH-1:0] mem_cke_t;

	// one half-rate word, low slot in the lower half
	typedef logic [2*`MEM_ADDRESS_WIDTH-1:0] afi_addr_t;
	typedef logic [2*`MEM_CHIP_SELECT_WIDTH-1:0] afi_cs_n_t;
	typedef logic [2*`MEM_CLK_EN_WIDTH-1:0] afi_cke_t;

	typedef logic [`MEM_CK_WIDTH-1:0] mem_ck_t;

	// each state names the slot currently on the pins
	typedef enum logic [1:0]
	{
		IDLE,
		SEND_LO,
		SEND_HI
	} ser_state_t;

endpackage

`default_nettype wire

// ==== verilog/afi_cmd_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module afi_cmd_capture (
	input wire logic pll_afi_clk,
	input wire logic arst_n,
	input wire logic cmd_req,
	input wire addr_cmd_pkg::afi_addr_t afi_address,
	input wire addr_cmd_pkg::afi_cs_n_t afi_cs_n,
	input wire addr_cmd_pkg::afi_cke_t afi_cke,
	input wire logic word_take,
	output logic cmd_ack,
	output logic word_valid,
	output addr_cmd_pkg::afi_addr_t word_address,
	output addr_cmd_pkg::afi_cs_n_t word_cs_n,
	output addr_cmd_pkg::afi_cke_t word_cke
);

	logic latch;

	// a full buffer holds off the latch, and with it the ack
	assign latch = cmd_req && !cmd_ack && !word_valid;

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cmd_ack <= 1'b0;
		end
		else if (latch)
		begin
			cmd_ack <= 1'b1;
		end
		else if (cmd_ack && !cmd_req)
		begin
			cmd_ack <= 1'b0;
		end
	end

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			word_valid <= 1'b0;
		end
		else if (latch)
		begin
			word_valid <= 1'b1;
		end
		else if (word_take)
		begin
			word_valid <= 1'b0;
		end
	end

	always_ff @(posedge pll_afi_clk)
	begin
		if (latch)
		begin
			word_address <= afi_address;
			word_cs_n <= afi_cs_n;
			word_cke <= afi_cke;
		end
	end

	// the host may only release req once it has seen ack
	req_held_until_ack: assert property (
		@(posedge pll_afi_clk) disable iff (!arst_n)
		$fell(cmd_req) |-> $past(cmd_ack)
	);

	// with the C2P register the take arrives late, so the buffer must still be full
	take_only_when_full: assert property (
		@(posedge pll_afi_clk) disable iff (!arst_n)
		word_take |-> word_valid
	);

endmodule

`default_nettype wire

// ==== verilog/ddr_addr_cmd_phy.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_addr_cmd_phy #(
	parameter int REGISTER_C2P = 1
) (
	input wire logic pll_afi_clk,
	input wire logic arst_n,
	input wire logic cmd_req,
	input wire addr_cmd_pkg::afi_addr_t afi_address,
	input wire addr_cmd_pkg::afi_cs_n_t afi_cs_n,
	input wire addr_cmd_pkg::afi_cke_t afi_cke,
	input wire addr_cmd_pkg::mem_ck_t mem_clk_enable,
	output logic cmd_ack,
	output addr_cmd_pkg::mem_addr_t mem_address,
	output addr_cmd_pkg::mem_cs_n_t mem_cs_n,
	output addr_cmd_pkg::mem_cke_t mem_cke,
	output addr_cmd_pkg::mem_ck_t mem_ck,
	output addr_cmd_pkg::mem_ck_t mem_ck_n
);

	import addr_cmd_pkg::*;

	logic word_valid;
	logic word_take;
	afi_addr_t word_address;
	afi_cs_n_t word_cs_n;
	afi_cke_t word_cke;

	afi_cmd_capture capture_i (
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.cmd_req(cmd_req),
		.afi_address(afi_address),
		.afi_cs_n(afi_cs_n),
		.afi_cke(afi_cke),
		.word_take(word_take),
		.cmd_ack(cmd_ack),
		.word_valid(word_valid),
		.word_address(word_address),
		.word_cs_n(word_cs_n),
		.word_cke(word_cke)
	);

	addr_cmd_pads #(
		.REGISTER_C2P(REGISTER_C2P)
	) pads_i (
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.word_valid(word_valid),
		.word_address(word_address),
		.word_cs_n(word_cs_n),
		.word_cke(word_cke),
		.mem_clk_enable(mem_clk_enable),
		.word_take(word_take),
		.mem_address(mem_address),
		.mem_cs_n(mem_cs_n),
		.mem_cke(mem_cke),
		.mem_ck(mem_ck),
		.mem_ck_n(mem_ck_n)
	);

endmodule

`default_nettype wire

// ==== verilog/ddr_phy_consts.svh ====
`ifndef DDR_PHY_CONSTS_SVH
`define DDR_PHY_CONSTS_SVH

// pin counts of one full-rate slot
`define MEM_ADDRESS_WIDTH 14
`define MEM_CHIP_SELECT_WIDTH 2
`define MEM_CLK_EN_WIDTH 2
`define MEM_CK_WIDTH 1

// all chip selects high deselects every rank
`define NOP_CS_N {`MEM_CHIP_SELECT_WIDTH{1'b1}}

// cke low keeps the memory in its power-up state until the controller raises it
`define RESET_CKE {`MEM_CLK_EN_WIDTH{1'b0}}

`endif

// ==== verilog/hr_to_fr_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_phy_consts.svh"

module hr_to_fr_serializer (
	input wire logic pll_afi_clk,
	input wire logic arst_n,
	input wire logic word_valid,
	input wire addr_cmd_pkg::afi_addr_t word_address,
	input wire addr_cmd_pkg::afi_cs_n_t word_cs_n,
	input wire addr_cmd_pkg::afi_cke_t word_cke,
	output logic word_take,
	output addr_cmd_pkg::mem_addr_t mem_address,
	output addr_cmd_pkg::mem_cs_n_t mem_cs_n,
	output addr_cmd_pkg::mem_cke_t mem_cke
);

	import addr_cmd_pkg::*;

	ser_state_t state;

	mem_addr_t lo_address;
	mem_addr_t hi_address;
	mem_cs_n_t lo_cs_n;
	mem_cs_n_t hi_cs_n;
	mem_cke_t lo_cke;
	mem_cke_t hi_cke;

	mem_addr_t hi_address_q;
	mem_cs_n_t hi_cs_n_q;
	mem_cke_t hi_cke_q;

	assign lo_address = word_address[`MEM_ADDRESS_WIDTH-1:0];
	assign hi_address = word_address[2*`MEM_ADDRESS_WIDTH-1:`MEM_ADDRESS_WIDTH];
	assign lo_cs_n = word_cs_n[`MEM_CHIP_SELECT_WIDTH-1:0];
	assign hi_cs_n = word_cs_n[2*`MEM_CHIP_SELECT_WIDTH-1:`MEM_CHIP_SELECT_WIDTH];
	assign lo_cke = word_cke[`MEM_CLK_EN_WIDTH-1:0];
	assign hi_cke = word_cke[2*`MEM_CLK_EN_WIDTH-1:`MEM_CLK_EN_WIDTH];

	// taking during the high slot lets consecutive words stream without a gap
	assign word_take = word_valid && (state == IDLE || state == SEND_HI);

	// the low slot goes straight to the pins, only the high slot waits a cycle
	always_ff @(posedge pll_afi_clk)
	begin
		if (word_take)
		begin
			hi_address_q <= hi_address;
			hi_cs_n_q <= hi_cs_n;
			hi_cke_q <= hi_cke;
		end
	end

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= IDLE;
			mem_address <= '0;
			mem_cs_n <= `NOP_CS_N;
			mem_cke <= `RESET_CKE;
		end
		else
		begin
			case (state)
				IDLE, SEND_HI:
				begin
					if (word_take)
					begin
						state <= SEND_LO;
						mem_address <= lo_address;
						mem_cs_n <= lo_cs_n;
						mem_cke <= lo_cke;
					end
					else
					begin
						// NOP slot, cke stays where the last command left it
						state <= IDLE;
						mem_address <= '0;
						mem_cs_n <= `NOP_CS_N;
					end
				end
				SEND_LO:
				begin
					state <= SEND_HI;
					mem_address <= hi_address_q;
					mem_cs_n <= hi_cs_n_q;
					mem_cke <= hi_cke_q;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	idle_drives_nop: assert property (
		@(posedge pll_afi_clk) disable iff (!arst_n)
		(state == IDLE) |-> (mem_cs_n == `NOP_CS_N)
	);

endmodule

`default_nettype wire

// ==== verilog/mem_ck_pair_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_phy_consts.svh"

module mem_ck_pair_gen (
	input wire logic pll_afi_clk,
	input wire logic arst_n,
	input wire addr_cmd_pkg::mem_ck_t mem_clk_enable,
	output addr_cmd_pkg::mem_ck_t mem_ck,
	output addr_cmd_pkg::mem_ck_t mem_ck_n
);

	import addr_cmd_pkg::*;

	wire mem_ck_t ck_q;

	genvar i;
	generate
		for (i = 0; i < `MEM_CK_WIDTH; i++)
		begin : g_pair
			logic tgl_q;

			// a disabled pair parks low one cycle after its enable drops
			always_ff @(posedge pll_afi_clk or negedge arst_n)
			begin
				if (!arst_n)
				begin
					tgl_q <= 1'b0;
				end
				else
				begin
					tgl_q <= mem_clk_enable[i] && !tgl_q;
				end
			end

			assign ck_q[i] = tgl_q;
		end
	endgenerate

	// both legs come from the one register so they cannot drift apart
	assign mem_ck = ck_q;
	assign mem_ck_n = ~ck_q;

	ck_pair_complementary: assert property (
		@(posedge pll_afi_clk) disable iff (!arst_n)
		(mem_ck ^ mem_ck_n) == {`MEM_CK_WIDTH{1'b1}}
	);

endmodule

`default_nettype wire
